/* Bender.yml */
package:
  name: versatMem

sources:
  - logic/versatDataPkg.sv
  - logic/versatCfgPkg.sv
  - logic/addrGen.sv
  - logic/dualPortRam.sv
  - logic/memUnit.sv
  - logic/cfgRegs.sv
  - logic/versatMemTop.sv
  - target: simulation
    files:
      - sim/clkGen.sv
      - sim/memUnit_properties.sv
      - sim/versatMemTb.sv

/* logic/addrGen.sv */
`timescale 1ns/1ns

module addrGen (
   input  logic                             clk,
   input  logic                             rstN,
   input  logic                             init,
   input  logic                             run,
   input  logic [versatDataPkg::addrW-1:0]  iterations,
   input  logic [versatCfgPkg::periodW-1:0] period,
   input  logic [versatCfgPkg::periodW-1:0] duty,
   input  logic [versatDataPkg::addrW-1:0]  start,
   input  logic [versatDataPkg::addrW-1:0]  shift,
   input  logic [versatDataPkg::addrW-1:0]  incr,
   input  logic [versatCfgPkg::periodW-1:0] delay,
   output logic [versatDataPkg::addrW-1:0]  addr,
   output logic                             memEn,
   output logic                             done
);
   import versatDataPkg::*;
   import versatCfgPkg::*;

   typedef enum logic [1:0] {idle, waiting, running} genState_e;

   genState_e          state;
   logic [periodW-1:0] delayCnt;
   logic [periodW-1:0] periodCnt;
   logic [addrW-1:0]   iterCnt;
   logic [addrW-1:0]   baseAddr;
   logic               periodEnd;
   logic               lastPeriod;

   assign done  = (state == idle);
   assign memEn = (state == running) && (periodCnt < duty);

   // a zero period behaves like a period of one cycle
   assign periodEnd  = ({1'b0, periodCnt} + 1'b1) >= {1'b0, period};
   assign lastPeriod = (iterCnt + 1'b1) >= iterations;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state     <= idle;
         delayCnt  <= '0;
         periodCnt <= '0;
         iterCnt   <= '0;
         baseAddr  <= '0;
         addr      <= '0;
      end else if (init) begin
         state     <= idle;
         delayCnt  <= '0;
         periodCnt <= '0;
         iterCnt   <= '0;
         baseAddr  <= start;
         addr      <= start;
      end else begin
         case (state)
            idle: begin
               if (run) begin
                  delayCnt <= delay;
                  state    <= (delay == '0) ? running : waiting;
               end
            end
            waiting: begin
               delayCnt <= delayCnt - 1'b1;
               if (delayCnt == periodW'(1))
                  state <= running;
            end
            running: begin
               if (periodEnd) begin
                  // next period starts from the shifted base
                  periodCnt <= '0;
                  baseAddr  <= baseAddr + shift;
                  addr      <= baseAddr + shift;
                  if (lastPeriod) begin
                     iterCnt <= '0;
                     state   <= idle;
                  end else begin
                     iterCnt <= iterCnt + 1'b1;
                  end
               end else begin
                  periodCnt <= periodCnt + 1'b1;
                  if (memEn)
                     addr <= addr + incr;
               end
            end
            default: state <= idle;
         endcase
      end
   end

endmodule

/* logic/cfgRegs.sv */
`timescale 1ns/1ns

module cfgRegs (
   input  logic                             clk,
   input  logic                             rstN,
   input  logic                             cfgWrite,
   input  logic                             cfgPort,
   input  versatCfgPkg::cfgField_e          cfgField,
   input  logic [versatDataPkg::dataW-1:0]  cfgData,
   output logic [versatDataPkg::addrW-1:0]  iterA,
   output logic [versatCfgPkg::periodW-1:0] periodA,
   output logic [versatCfgPkg::periodW-1:0] dutyA,
   output logic [versatDataPkg::addrW-1:0]  startA,
   output logic [versatDataPkg::addrW-1:0]  shiftA,
   output logic [versatDataPkg::addrW-1:0]  incrA,
   output logic [versatCfgPkg::periodW-1:0] delayA,
   output versatCfgPkg::memSel_e            selA,
   output logic                             reverseA,
   output logic [versatDataPkg::addrW-1:0]  iterB,
   output logic [versatCfgPkg::periodW-1:0] periodB,
   output logic [versatCfgPkg::periodW-1:0] dutyB,
   output logic [versatDataPkg::addrW-1:0]  startB,
   output logic [versatDataPkg::addrW-1:0]  shiftB,
   output logic [versatDataPkg::addrW-1:0]  incrB,
   output logic [versatCfgPkg::periodW-1:0] delayB,
   output versatCfgPkg::memSel_e            selB,
   output logic                             reverseB
);
   import versatDataPkg::*;
   import versatCfgPkg::*;

   // index 0 is port A, 1 is port B
   logic [addrW-1:0]   iterR   [2];
   logic [periodW-1:0] periodR [2];
   logic [periodW-1:0] dutyR   [2];
   logic [addrW-1:0]   startR  [2];
   logic [addrW-1:0]   shiftR  [2];
   logic [addrW-1:0]   incrR   [2];
   logic [periodW-1:0] delayR  [2];
   logic [3:0]         modeR   [2];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int p = 0; p < 2; p++) begin
            iterR[p]   <= '0;
            periodR[p] <= '0;
            dutyR[p]   <= '0;
            startR[p]  <= '0;
            shiftR[p]  <= '0;
            incrR[p]   <= '0;
            delayR[p]  <= '0;
            modeR[p]   <= '0;
         end
      end else if (cfgWrite) begin
         // data is truncated to the field width
         case (cfgField)
            fieldIter:   iterR[cfgPort]   <= cfgData[addrW-1:0];
            fieldPeriod: periodR[cfgPort] <= cfgData[periodW-1:0];
            fieldDuty:   dutyR[cfgPort]   <= cfgData[periodW-1:0];
            fieldStart:  startR[cfgPort]  <= cfgData[addrW-1:0];
            fieldShift:  shiftR[cfgPort]  <= cfgData[addrW-1:0];
            fieldIncr:   incrR[cfgPort]   <= cfgData[addrW-1:0];
            fieldDelay:  delayR[cfgPort]  <= cfgData[periodW-1:0];
            fieldMode:   modeR[cfgPort]   <= cfgData[3:0];
         endcase
      end
   end

   assign iterA    = iterR[0];
   assign periodA  = periodR[0];
   assign dutyA    = dutyR[0];
   assign startA   = startR[0];
   assign shiftA   = shiftR[0];
   assign incrA    = incrR[0];
   assign delayA   = delayR[0];
   assign selA     = memSel_e'(modeR[0][2:0]);
   assign reverseA = modeR[0][3];

   assign iterB    = iterR[1];
   assign periodB  = periodR[1];
   assign dutyB    = dutyR[1];
   assign startB   = startR[1];
   assign shiftB   = shiftR[1];
   assign incrB    = incrR[1];
   assign delayB   = delayR[1];
   assign selB     = memSel_e'(modeR[1][2:0]);
   assign reverseB = modeR[1][3];

endmodule

/* logic/dualPortRam.sv */
`timescale 1ns/1ns

module dualPortRam (
   input  logic                            clk,
   input  logic                            enA,
   input  logic                            wrA,
   input  logic [versatDataPkg::addrW-1:0] addrA,
   input  logic [versatDataPkg::dataW-1:0] wrDataA,
   output logic [versatDataPkg::dataW-1:0] rdDataA,
   input  logic                            enB,
   input  logic                            wrB,
   input  logic [versatDataPkg::addrW-1:0] addrB,
   input  logic [versatDataPkg::dataW-1:0] wrDataB,
   output logic [versatDataPkg::dataW-1:0] rdDataB
);
   import versatDataPkg::*;

   logic [dataW-1:0] mem [2**addrW];

   always_ff @(posedge clk) begin
      if (enA && wrA)
         mem[addrA] <= wrDataA;
      // port B last, so it wins a same-address collision
      if (enB && wrB)
         mem[addrB] <= wrDataB;
   end

   // write-first outputs, held while the port is idle
   always_ff @(posedge clk) begin
      if (enA)
         rdDataA <= wrA ? wrDataA : mem[addrA];
      if (enB)
         rdDataB <= wrB ? wrDataB : mem[addrB];
   end

endmodule

/* logic/memUnit.sv */
`timescale 1ns/1ns

module memUnit (
   input  logic                                        clk,
   input  logic                                        rstN,
   input  logic                                        initA,
   input  logic                                        initB,
   input  logic                                        runA,
   input  logic                                        runB,
   input  logic [versatDataPkg::addrW-1:0]             iterA,
   input  logic [versatCfgPkg::periodW-1:0]            periodA,
   input  logic [versatCfgPkg::periodW-1:0]            dutyA,
   input  logic [versatDataPkg::addrW-1:0]             startA,
   input  logic [versatDataPkg::addrW-1:0]             shiftA,
   input  logic [versatDataPkg::addrW-1:0]             incrA,
   input  logic [versatCfgPkg::periodW-1:0]            delayA,
   input  versatCfgPkg::memSel_e                       selA,
   input  logic                                        reverseA,
   input  logic [versatDataPkg::addrW-1:0]             iterB,
   input  logic [versatCfgPkg::periodW-1:0]            periodB,
   input  logic [versatCfgPkg::periodW-1:0]            dutyB,
   input  logic [versatDataPkg::addrW-1:0]             startB,
   input  logic [versatDataPkg::addrW-1:0]             shiftB,
   input  logic [versatDataPkg::addrW-1:0]             incrB,
   input  logic [versatCfgPkg::periodW-1:0]            delayB,
   input  versatCfgPkg::memSel_e                       selB,
   input  logic                                        reverseB,
   input  logic                                        ctrReq,
   input  logic                                        ctrRnw,
   input  logic [versatDataPkg::addrW-1:0]             ctrAddr,
   input  logic [versatDataPkg::dataW-1:0]             ctrWrData,
   input  logic [versatDataPkg::flowN*versatDataPkg::dataW-1:0] flowIn,
   output logic [versatDataPkg::dataW-1:0]             ctrRdData,
   output logic [versatDataPkg::dataW-1:0]             flowOutA,
   output logic [versatDataPkg::dataW-1:0]             flowOutB,
   output logic                                        doneA,
   output logic                                        doneB
);
   import versatDataPkg::*;
   import versatCfgPkg::*;

   logic             readyA, readyB;
   logic [addrW-1:0] genAddrA, genAddrB;
   logic [addrW-1:0] effAddrA, effAddrB;
   logic             memEnA, memEnB;
   logic             genWrA, genWrB;
   logic [dataW-1:0] wordA, wordB;
   logic             ramEnB, ramWrB;
   logic [addrW-1:0] ramAddrB;
   logic [dataW-1:0] ramWrDataB;
   logic [dataW-1:0] rdDataA, rdDataB;
   logic [addrW-1:0] addrOutA, addrOutB;

   function automatic logic [addrW-1:0] reverseBits(input logic [addrW-1:0] word);
      logic [addrW-1:0] rev;
      for (int i = 0; i < addrW; i++)
         rev[i] = word[addrW-1-i];
      return rev;
   endfunction

   function automatic logic isFlowSel(input memSel_e sel);
      return sel inside {selFlow0, selFlow1, selFlow2, selFlow3};
   endfunction

   function automatic logic [dataW-1:0] pickFlow(input memSel_e sel,
                                                 input logic [flowN*dataW-1:0] flow);
      return flow[sel[1:0]*dataW +: dataW];
   endfunction

   // a port with zero iterations ignores run
   assign readyA = |iterA;
   assign readyB = |iterB;

   addrGen genA_i (
      .clk(clk), .rstN(rstN), .init(initA), .run(runA & readyA),
      .iterations(iterA), .period(periodA), .duty(dutyA),
      .start(startA), .shift(shiftA), .incr(incrA), .delay(delayA),
      .addr(genAddrA), .memEn(memEnA), .done(doneA)
   );

   addrGen genB_i (
      .clk(clk), .rstN(rstN), .init(initB), .run(runB & readyB),
      .iterations(iterB), .period(periodB), .duty(dutyB),
      .start(startB), .shift(shiftB), .incr(incrB), .delay(delayB),
      .addr(genAddrB), .memEn(memEnB), .done(doneB)
   );

   assign effAddrA = reverseA ? reverseBits(genAddrA) : genAddrA;
   assign effAddrB = reverseB ? reverseBits(genAddrB) : genAddrB;

   assign wordA  = pickFlow(selA, flowIn);
   assign wordB  = pickFlow(selB, flowIn);
   assign genWrA = memEnA && isFlowSel(selA);
   assign genWrB = memEnB && isFlowSel(selB);

   // controller takes port B over the generator
   assign ramEnB     = ctrReq | memEnB;
   assign ramWrB     = ctrReq ? ~ctrRnw : genWrB;
   assign ramAddrB   = ctrReq ? ctrAddr : effAddrB;
   assign ramWrDataB = ctrReq ? ctrWrData : wordB;

   dualPortRam ram_i (
      .clk(clk),
      .enA(memEnA), .wrA(genWrA), .addrA(effAddrA), .wrDataA(wordA), .rdDataA(rdDataA),
      .enB(ramEnB), .wrB(ramWrB), .addrB(ramAddrB), .wrDataB(ramWrDataB), .rdDataB(rdDataB)
   );

   // address stream output, aligned with the RAM read latency
   always_ff @(posedge clk) begin
      if (memEnA)
         addrOutA <= effAddrA;
      if (memEnB)
         addrOutB <= effAddrB;
   end

   assign flowOutA  = (selA == selAddr) ? {{(dataW-addrW){1'b0}}, addrOutA} : rdDataA;
   assign flowOutB  = (selB == selAddr) ? {{(dataW-addrW){1'b0}}, addrOutB} : rdDataB;
   assign ctrRdData = rdDataB;

endmodule

/* logic/versatCfgPkg.sv */
package versatCfgPkg;

   // period, duty and delay counters
   localparam int periodW = 5;

   // flow selector of a port
   typedef enum logic [2:0] {
      selFlow0 = 3'd0,
      selFlow1 = 3'd1,
      selFlow2 = 3'd2,
      selFlow3 = 3'd3,
      selAddr  = 3'd4,
      selNone  = 3'd5
   } memSel_e;

   // configuration registers of one port
   typedef enum logic [2:0] {
      fieldIter   = 3'd0,
      fieldPeriod = 3'd1,
      fieldDuty   = 3'd2,
      fieldStart  = 3'd3,
      fieldShift  = 3'd4,
      fieldIncr   = 3'd5,
      fieldDelay  = 3'd6,
      // selector in bits 2..0, reverse in bit 3
      fieldMode   = 3'd7
   } cfgField_e;

endpackage

/* logic/versatDataPkg.sv */
package versatDataPkg;

   // width of one data word on the flow bus and in the RAM
   localparam int dataW = 16;

   // RAM address width, 256 words
   localparam int addrW = 8;

   // words carried on the flow bus
   localparam int flowN = 4;

endpackage

/* logic/versatMemTop.sv */
`timescale 1ns/1ns

module versatMemTop (
   input  logic                                        clk,
   input  logic                                        rstN,
   input  logic                                        cfgWrite,
   input  logic                                        cfgPort,
   input  versatCfgPkg::cfgField_e                     cfgField,
   input  logic [versatDataPkg::dataW-1:0]             cfgData,
   input  logic                                        initA,
   input  logic                                        initB,
   input  logic                                        runA,
   input  logic                                        runB,
   input  logic                                        ctrReq,
   input  logic                                        ctrRnw,
   input  logic [versatDataPkg::addrW-1:0]             ctrAddr,
   input  logic [versatDataPkg::dataW-1:0]             ctrWrData,
   input  logic [versatDataPkg::flowN*versatDataPkg::dataW-1:0] flowIn,
   output logic [versatDataPkg::dataW-1:0]             ctrRdData,
   output logic [versatDataPkg::dataW-1:0]             flowOutA,
   output logic [versatDataPkg::dataW-1:0]             flowOutB,
   output logic                                        doneA,
   output logic                                        doneB
);
   import versatDataPkg::*;
   import versatCfgPkg::*;

   logic [addrW-1:0]   iterA, startA, shiftA, incrA;
   logic [addrW-1:0]   iterB, startB, shiftB, incrB;
   logic [periodW-1:0] periodA, dutyA, delayA;
   logic [periodW-1:0] periodB, dutyB, delayB;
   memSel_e            selA, selB;
   logic               reverseA, reverseB;

   cfgRegs cfgRegs_i (
      .clk(clk), .rstN(rstN), .cfgWrite(cfgWrite), .cfgPort(cfgPort),
      .cfgField(cfgField), .cfgData(cfgData),
      .iterA(iterA), .periodA(periodA), .dutyA(dutyA), .startA(startA),
      .shiftA(shiftA), .incrA(incrA), .delayA(delayA), .selA(selA), .reverseA(reverseA),
      .iterB(iterB), .periodB(periodB), .dutyB(dutyB), .startB(startB),
      .shiftB(shiftB), .incrB(incrB), .delayB(delayB), .selB(selB), .reverseB(reverseB)
   );

   memUnit memUnit_i (
      .clk(clk), .rstN(rstN),
      .initA(initA), .initB(initB), .runA(runA), .runB(runB),
      .iterA(iterA), .periodA(periodA), .dutyA(dutyA), .startA(startA),
      .shiftA(shiftA), .incrA(incrA), .delayA(delayA), .selA(selA), .reverseA(reverseA),
      .iterB(iterB), .periodB(periodB), .dutyB(dutyB), .startB(startB),
      .shiftB(shiftB), .incrB(incrB), .delayB(delayB), .selB(selB), .reverseB(reverseB),
      .ctrReq(ctrReq), .ctrRnw(ctrRnw), .ctrAddr(ctrAddr), .ctrWrData(ctrWrData),
      .flowIn(flowIn),
      .ctrRdData(ctrRdData), .flowOutA(flowOutA), .flowOutB(flowOutB),
      .doneA(doneA), .doneB(doneB)
   );

endmodule

/* sim/clkGen.sv */
`timescale 1ns/1ns

module clkGen (
   output logic clk
);
   // 8 ns period
   localparam int halfPeriod = 4;

   initial begin
      clk = 1'b0;
      forever #halfPeriod clk = ~clk;
   end

endmodule

/* sim/memUnit_properties.sv */
`timescale 1ns/1ns

module memUnitProperties (
   input logic                            clk,
   input logic                            rstN,
   input logic                            doneA,
   input logic                            doneB,
   input logic                            memEnA,
   input logic                            memEnB,
   input logic                            ctrReq,
   input logic                            ctrRnw,
   input logic [versatDataPkg::dataW-1:0] ctrWrData,
   input logic [versatDataPkg::dataW-1:0] ctrRdData
);

   idleNoEnA: assert property (@(posedge clk) disable iff (!rstN) doneA |-> !memEnA)
      else $error("port A generator enabled while done");

   idleNoEnB: assert property (@(posedge clk) disable iff (!rstN) doneB |-> !memEnB)
      else $error("port B generator enabled while done");

   doneAfterReset: assert property (@(posedge clk) !rstN |=> (doneA && doneB))
      else $error("done low in the cycle after reset");

   // controller owns port B, so its write word is the one that lands
   ctrOwnsB: assert property (@(posedge clk) disable iff (!rstN)
      (ctrReq && !ctrRnw) |=> (ctrRdData == $past(ctrWrData)))
      else $error("controller write on port B did not return its own word");

endmodule

bind memUnit memUnitProperties props_i (
   .clk(clk), .rstN(rstN), .doneA(doneA), .doneB(doneB),
   .memEnA(memEnA), .memEnB(memEnB), .ctrReq(ctrReq), .ctrRnw(ctrRnw),
   .ctrWrData(ctrWrData), .ctrRdData(ctrRdData)
);

/* sim/versatMemTb.sv */
`timescale 1ns/1ns

module versatMemTb;
   import versatDataPkg::*;
   import versatCfgPkg::*;

   logic                   clk, rstN, cfgWrite, cfgPort;
   cfgField_e              cfgField;
   logic [dataW-1:0]       cfgData;
   logic                   initA, initB, runA, runB;
   logic                   ctrReq, ctrRnw;
   logic [addrW-1:0]       ctrAddr;
   logic [dataW-1:0]       ctrWrData;
   logic [flowN*dataW-1:0] flowIn;
   logic [dataW-1:0]       ctrRdData, flowOutA, flowOutB;
   logic                   doneA, doneB;

   // reference copy of the RAM
   logic [dataW-1:0] memModel [256];
   logic [15:0]      lfsr;

   // current port configuration
   logic [addrW-1:0]   cIter, cStart, cShift, cIncr;
   logic [periodW-1:0] cPeriod, cDuty, cDelay;
   memSel_e            cSel;
   logic               cRev;

   // predicted cycles of a stream, delay cycles included
   logic             schedEn [$];
   logic [addrW-1:0] schedAddr [$];

   // last word predicted on port A
   logic [dataW-1:0] lastOutA;

   clkGen clkGen_i (.clk(clk));

   versatMemTop dut_i (
      .clk(clk), .rstN(rstN), .cfgWrite(cfgWrite), .cfgPort(cfgPort),
      .cfgField(cfgField), .cfgData(cfgData),
      .initA(initA), .initB(initB), .runA(runA), .runB(runB),
      .ctrReq(ctrReq), .ctrRnw(ctrRnw), .ctrAddr(ctrAddr), .ctrWrData(ctrWrData),
      .flowIn(flowIn), .ctrRdData(ctrRdData), .flowOutA(flowOutA), .flowOutB(flowOutB),
      .doneA(doneA), .doneB(doneB)
   );

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic logic [addrW-1:0] flipAddr(input logic [addrW-1:0] a);
      logic [addrW-1:0] r;
      for (int i = 0; i < addrW; i++)
         r[addrW-1-i] = a[i];
      return r;
   endfunction

   task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string msg);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
         $display(">>> FAIL");
         $fatal(1);
      end
   endtask

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic waitDone(input logic port);
      int cycles;
      cycles = 0;
      while (!(port ? doneB : doneA) && cycles < 300) begin
         step();
         cycles++;
      end
      if (!(port ? doneB : doneA)) begin
         $display("Timeout: done never rose on port %s", port ? "B" : "A");
         $display(">>> FAIL");
         $fatal(1);
      end
   endtask

   task automatic setField(input logic port, input cfgField_e f, input logic [dataW-1:0] v);
      cfgWrite = 1'b1;
      cfgPort  = port;
      cfgField = f;
      cfgData  = v;
      step();
      cfgWrite = 1'b0;
   endtask

   task automatic ctrWrite(input logic [addrW-1:0] a, input logic [dataW-1:0] d);
      ctrReq    = 1'b1;
      ctrRnw    = 1'b0;
      ctrAddr   = a;
      ctrWrData = d;
      memModel[a] = d;
      step();
      ctrReq = 1'b0;
   endtask

   // reads every word back through the controller
   task automatic checkMemory();
      for (int a = 0; a < 256; a++) begin
         ctrReq  = 1'b1;
         ctrRnw  = 1'b1;
         ctrAddr = addrW'(a);
         step();
         checkEq(ctrRdData, memModel[a], "controller read");
      end
      ctrReq = 1'b0;
   endtask

   task automatic randomConfig(input memSel_e sel, input logic rev);
      cIter   = addrW'(randBits(2) + 1);
      cPeriod = periodW'(randBits(3) + 1);
      cDuty   = periodW'(randBits(3) + 1);
      cStart  = addrW'(randBits(8));
      cShift  = addrW'(randBits(8));
      cIncr   = addrW'(randBits(8));
      cDelay  = periodW'(randBits(3));
      cSel    = sel;
      cRev    = rev;
   endtask

   task automatic writeConfig(input logic port);
      setField(port, fieldIter, dataW'(cIter));
      setField(port, fieldPeriod, dataW'(cPeriod));
      setField(port, fieldDuty, dataW'(cDuty));
      setField(port, fieldStart, dataW'(cStart));
      setField(port, fieldShift, dataW'(cShift));
      setField(port, fieldIncr, dataW'(cIncr));
      setField(port, fieldDelay, dataW'(cDelay));
      setField(port, fieldMode, dataW'({cRev, cSel}));
   endtask

   task automatic buildSchedule();
      logic [addrW-1:0] addr;
      logic [addrW-1:0] base;
      schedEn.delete();
      schedAddr.delete();
      addr = cStart;
      base = cStart;
      for (int d = 0; d < cDelay; d++) begin
         schedEn.push_back(1'b0);
         schedAddr.push_back('0);
      end
      for (int i = 0; i < cIter; i++) begin
         for (int pc = 0; pc < cPeriod; pc++) begin
            schedEn.push_back(pc < cDuty);
            schedAddr.push_back(cRev ? flipAddr(addr) : addr);
            // a period ends on its shifted start address
            if (pc == cPeriod - 1) begin
               base = base + cShift;
               addr = base;
            end else if (pc < cDuty) begin
               addr = addr + cIncr;
            end
         end
      end
   endtask

   task automatic runStream(input logic port);
      int               total;
      logic [dataW-1:0] expOut;
      expOut = '0;
      waitDone(port);
      buildSchedule();
      total = schedEn.size();
      initA = !port;
      initB = port;
      step();
      initA = 1'b0;
      initB = 1'b0;
      runA  = !port;
      runB  = port;
      for (int j = 0; j <= total; j++) begin
         step();
         runA = 1'b0;
         runB = 1'b0;
         if (j > 0 && schedEn[j-1])
            checkEq(port ? flowOutB : flowOutA, expOut, "stream word");
         checkEq(32'(port ? doneB : doneA), 32'(j == total), "done level");
         if (j < total) begin
            flowIn = {randBits(32), randBits(32)};
            if (schedEn[j]) begin
               if (cSel == selAddr) begin
                  expOut = dataW'(schedAddr[j]);
               end else if (cSel == selNone) begin
                  expOut = memModel[schedAddr[j]];
               end else begin
                  expOut = flowIn[cSel[1:0]*dataW +: dataW];
                  memModel[schedAddr[j]] = expOut;
               end
            end
         end
      end
      if (!port)
         lastOutA = expOut;
   endtask

   initial begin
      rstN      = 1'b0;
      cfgWrite  = 1'b0;
      cfgPort   = 1'b0;
      cfgField  = fieldIter;
      cfgData   = '0;
      initA     = 1'b0;
      initB     = 1'b0;
      runA      = 1'b0;
      runB      = 1'b0;
      ctrReq    = 1'b0;
      ctrRnw    = 1'b1;
      ctrAddr   = '0;
      ctrWrData = '0;
      flowIn    = '0;
      lastOutA  = '0;
      lfsr      = 16'd7549;
      repeat (5) @(posedge clk);
      #1;
      rstN = 1'b1;
      checkEq(32'(doneA), 32'd1, "doneA after reset");
      checkEq(32'(doneB), 32'd1, "doneB after reset");

      // controller fill, some random overwrites, full readback
      for (int a = 0; a < 256; a++)
         ctrWrite(addrW'(a), dataW'(randBits(16)));
      repeat (16)
         ctrWrite(addrW'(randBits(8)), dataW'(randBits(16)));
      checkMemory();

      repeat (4) begin
         randomConfig(selNone, 1'b0);
         writeConfig(1'b0);
         runStream(1'b0);
      end

      repeat (4) begin
         randomConfig(memSel_e'(randBits(2)), 1'b0);
         writeConfig(1'b1);
         runStream(1'b1);
      end
      checkMemory();

      repeat (3) begin
         randomConfig(selNone, 1'b1);
         writeConfig(1'b0);
         runStream(1'b0);
      end

      // address output must leave memory untouched
      repeat (3) begin
         randomConfig(selAddr, randBits(1) != 0);
         writeConfig(1'b1);
         runStream(1'b1);
      end
      checkMemory();

      // zero iterations, run is ignored
      setField(1'b0, fieldIter, '0);
      runA = 1'b1;
      for (int k = 0; k < 6; k++) begin
         step();
         runA = 1'b0;
         checkEq(32'(doneA), 32'd1, "doneA with zero iterations");
         checkEq(flowOutA, lastOutA, "flowOutA with zero iterations");
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

/* versatMem.f */
logic/versatDataPkg.sv
logic/versatCfgPkg.sv
logic/addrGen.sv
logic/dualPortRam.sv
logic/memUnit.sv
logic/cfgRegs.sv
logic/versatMemTop.sv
sim/clkGen.sv
sim/memUnit_properties.sv
sim/versatMemTb.sv
